/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes of the 32-bit encoding
    typedef enum logic [6:0] {
        OPC_LOAD    = 7'b000_0011,
        OPC_STORE   = 7'b010_0011,
        OPC_OP      = 7'b011_0011,
        OPC_OP_IMM  = 7'b001_0011,
        OPC_LUI     = 7'b011_0111,
        OPC_AUIPC   = 7'b001_0111,
        OPC_JAL     = 7'b110_1111,
        OPC_JALR    = 7'b110_0111,
        OPC_BRANCH  = 7'b110_0011,
        OPC_SYSTEM  = 7'b111_0011,
        OPC_CUSTOM0 = 7'b000_1011
    } opcode_e;

    // Write-back source select
    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_MEM  = 3'd1,
        WB_PC4  = 3'd2,
        WB_IMM  = 3'd3,
        WB_NONE = 3'd4
    } wb_sel_e;

    // One-hot data size codes
    localparam logic [3:0] DSIZE_NONE = 4'b0000;
    localparam logic [3:0] DSIZE_B    = 4'b0001;
    localparam logic [3:0] DSIZE_H    = 4'b0010;
    localparam logic [3:0] DSIZE_W    = 4'b0100;

    // Low two bits of every 32-bit instruction
    localparam logic [1:0] ENC_32BIT = 2'b11;

    // Legal funct7 values for register-register ops
    localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

endpackage

`default_nettype wire

/* design/core_if_stage.sv */
`default_nettype none

module core_if_stage import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic            instr_valid_i,
    input  logic            stall_i,
    output logic            if_valid_o,
    output logic [XLEN-1:0] if_pc_o,
    output logic [XLEN-1:0] if_instr_o,
    output logic            if_illegal_o
);

    logic [XLEN-1:0] pc_q;
    logic            accept;

    assign accept = instr_valid_i & ~stall_i;  // Word taken this cycle

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    assign if_valid_o   = instr_valid_i;
    assign if_pc_o      = pc_q;  // Pc of the word on instr_i
    assign if_instr_o   = instr_i;
    assign if_illegal_o = (instr_i[1:0] != ENC_32BIT);

endmodule

`default_nettype wire

/* design/core_if_id_reg.sv */
`default_nettype none

module core_if_id_reg import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            if_valid_i,
    input  logic [XLEN-1:0] if_pc_i,
    input  logic [XLEN-1:0] if_instr_i,
    input  logic            if_illegal_i,
    output logic            id_valid_o,
    output logic [XLEN-1:0] id_pc_o,
    output logic [XLEN-1:0] id_instr_o,
    output logic            id_illegal_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (flush_i) begin
            id_valid_o <= 1'b0;  // Flush beats stall
        end else if (!stall_i) begin
            id_valid_o <= if_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && if_valid_i) begin
            id_pc_o      <= if_pc_i;
            id_instr_o   <= if_instr_i;
            id_illegal_o <= if_illegal_i;
        end
    end

endmodule

`default_nettype wire

/* design/core_decoder.sv */
`default_nettype none

module core_decoder import core_pkg::*; (
    input  logic        valid_i,
    input  logic        illegal_i,
    input  logic [6:0]  opcode_i,
    input  logic [2:0]  funct3_i,
    input  logic [6:0]  funct7_i,
    output logic        reg_write_o,
    output logic        mem_read_o,
    output logic        mem_write_o,
    output wb_sel_e     wb_sel_o,
    output logic [3:0]  d_size_o,
    output logic        d_unsigned_o,
    output logic        dma_en_o
);

    opcode_e opcode;
    logic    active;
    logic    funct7_ok;
    logic    [3:0] size;

    assign opcode    = opcode_e'(opcode_i);
    assign active    = valid_i & ~illegal_i;
    assign funct7_ok = (funct7_i == FUNCT7_BASE) || (funct7_i == FUNCT7_ALT);

    // Access width from funct3[1:0]
    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size = DSIZE_B;
            2'b01:   size = DSIZE_H;
            2'b10:   size = DSIZE_W;
            default: size = DSIZE_NONE;
        endcase
    end

    always_comb begin
        reg_write_o  = 1'b0;
        mem_read_o   = 1'b0;
        mem_write_o  = 1'b0;
        wb_sel_o     = WB_NONE;
        d_size_o     = DSIZE_NONE;
        d_unsigned_o = 1'b0;
        dma_en_o     = 1'b0;
        if (active) begin
            case (opcode)
                OPC_LOAD: begin
                    reg_write_o  = 1'b1;
                    mem_read_o   = 1'b1;
                    wb_sel_o     = WB_MEM;
                    d_size_o     = size;
                    d_unsigned_o = funct3_i[2];  // LBU, LHU
                end
                OPC_STORE: begin
                    mem_write_o = 1'b1;
                    d_size_o    = size;
                end
                OPC_LUI: begin
                    reg_write_o = 1'b1;
                    wb_sel_o    = WB_IMM;
                end
                OPC_AUIPC: begin
                    reg_write_o = 1'b1;
                    wb_sel_o    = WB_ALU;  // Pc plus immediate
                end
                OPC_JAL, OPC_JALR: begin
                    reg_write_o = 1'b1;
                    wb_sel_o    = WB_PC4;
                end
                OPC_OP: begin
                    // Only base and alternate funct7 exist in RV32I
                    if (funct7_ok) begin
                        reg_write_o = 1'b1;
                        wb_sel_o    = WB_ALU;
                    end
                end
                OPC_OP_IMM: begin
                    reg_write_o = 1'b1;
                    wb_sel_o    = WB_ALU;
                end
                OPC_CUSTOM0: begin
                    dma_en_o = 1'b1;
                end
                default: begin
                    reg_write_o = 1'b0;  // Branch, system, unknown
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/core_imm_gen.sv */
`default_nettype none

module core_imm_gen import core_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output logic [XLEN-1:0] imm_o
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign sign   = instr_i[31];

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM: begin
                imm_o = {{20{sign}}, instr_i[31:20]};  // I-type
            end
            OPC_STORE: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;  // R-type and custom
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/core_regfile.sv */
`default_nettype none

module core_regfile import core_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       rd_din_i,
    input  logic                  reg_write_i,
    output logic [XLEN-1:0]       rs1_dout_o,
    output logic [XLEN-1:0]       rs2_dout_o
);

    logic [XLEN-1:0] regs [1:31];  // No storage for x0

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_din_i;
        end
    end

    // No bypass from the write port
    assign rs1_dout_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_dout_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* design/core_id_stage.sv */
`default_nettype none

module core_id_stage import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  id_valid_i,
    input  logic [XLEN-1:0]       id_pc_i,
    input  logic [XLEN-1:0]       id_instr_i,
    input  logic                  id_illegal_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_reg_write_i,
    output logic [6:0]            opcode_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [2:0]            funct3_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [6:0]            funct7_o,
    output logic                  reg_write_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output wb_sel_e               wb_sel_o,
    output logic [3:0]            d_size_o,
    output logic                  d_unsigned_o,
    output logic                  dma_en_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    output logic [XLEN-1:0]       pc_o,
    output logic                  valid_o,
    output logic                  illegal_o
);

    // Field slicing
    assign opcode_o = id_instr_i[6:0];
    assign rd_o     = id_instr_i[11:7];
    assign funct3_o = id_instr_i[14:12];
    assign rs1_o    = id_instr_i[19:15];
    assign rs2_o    = id_instr_i[24:20];
    assign funct7_o = id_instr_i[31:25];

    assign pc_o      = id_pc_i;
    assign valid_o   = id_valid_i;
    assign illegal_o = id_valid_i & id_illegal_i;  // Stale flag hidden when idle

    core_decoder u_decoder (
        .valid_i      (id_valid_i),
        .illegal_i    (id_illegal_i),
        .opcode_i     (opcode_o),
        .funct3_i     (funct3_o),
        .funct7_i     (funct7_o),
        .reg_write_o  (reg_write_o),
        .mem_read_o   (mem_read_o),
        .mem_write_o  (mem_write_o),
        .wb_sel_o     (wb_sel_o),
        .d_size_o     (d_size_o),
        .d_unsigned_o (d_unsigned_o),
        .dma_en_o     (dma_en_o)
    );

    core_imm_gen u_imm_gen (
        .instr_i (id_instr_i),
        .imm_o   (imm_o)
    );

    core_regfile #(
        .XLEN (XLEN)
    ) u_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rs1_i       (rs1_o),
        .rs2_i       (rs2_o),
        .rd_i        (wb_rd_i),
        .rd_din_i    (wb_data_i),
        .reg_write_i (wb_reg_write_i),
        .rs1_dout_o  (rs1_data_o),
        .rs2_dout_o  (rs2_data_o)
    );

endmodule

`default_nettype wire

/* design/core_front_top.sv */
`default_nettype none

module core_front_top import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       instr_i,
    input  logic                  instr_valid_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_reg_write_i,
    output logic [6:0]            id_opcode_o,
    output logic [REG_ADDR_W-1:0] id_rd_o,
    output logic [2:0]            id_funct3_o,
    output logic [REG_ADDR_W-1:0] id_rs1_o,
    output logic [REG_ADDR_W-1:0] id_rs2_o,
    output logic [6:0]            id_funct7_o,
    output logic                  id_reg_write_o,
    output logic                  id_mem_read_o,
    output logic                  id_mem_write_o,
    output wb_sel_e               id_wb_sel_o,
    output logic [3:0]            id_d_size_o,
    output logic                  id_d_unsigned_o,
    output logic                  id_dma_en_o,
    output logic [XLEN-1:0]       id_imm_o,
    output logic [XLEN-1:0]       id_rs1_data_o,
    output logic [XLEN-1:0]       id_rs2_data_o,
    output logic [XLEN-1:0]       id_pc_o,
    output logic                  id_valid_o,
    output logic                  id_illegal_o
);

    logic            if_valid;
    logic [XLEN-1:0] if_pc;
    logic [XLEN-1:0] if_instr;
    logic            if_illegal;
    logic            id_valid;
    logic [XLEN-1:0] id_pc;
    logic [XLEN-1:0] id_instr;
    logic            id_illegal;

    core_if_stage u_if_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .stall_i       (stall_i),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_instr_o    (if_instr),
        .if_illegal_o  (if_illegal)
    );

    core_if_id_reg u_if_id_reg (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .if_valid_i   (if_valid),
        .if_pc_i      (if_pc),
        .if_instr_i   (if_instr),
        .if_illegal_i (if_illegal),
        .id_valid_o   (id_valid),
        .id_pc_o      (id_pc),
        .id_instr_o   (id_instr),
        .id_illegal_o (id_illegal)
    );

    core_id_stage u_id_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .id_valid_i     (id_valid),
        .id_pc_i        (id_pc),
        .id_instr_i     (id_instr),
        .id_illegal_i   (id_illegal),
        .wb_rd_i        (wb_rd_i),
        .wb_data_i      (wb_data_i),
        .wb_reg_write_i (wb_reg_write_i),
        .opcode_o       (id_opcode_o),
        .rd_o           (id_rd_o),
        .funct3_o       (id_funct3_o),
        .rs1_o          (id_rs1_o),
        .rs2_o          (id_rs2_o),
        .funct7_o       (id_funct7_o),
        .reg_write_o    (id_reg_write_o),
        .mem_read_o     (id_mem_read_o),
        .mem_write_o    (id_mem_write_o),
        .wb_sel_o       (id_wb_sel_o),
        .d_size_o       (id_d_size_o),
        .d_unsigned_o   (id_d_unsigned_o),
        .dma_en_o       (id_dma_en_o),
        .imm_o          (id_imm_o),
        .rs1_data_o     (id_rs1_data_o),
        .rs2_data_o     (id_rs2_data_o),
        .pc_o           (id_pc_o),
        .valid_o        (id_valid_o),
        .illegal_o      (id_illegal_o)
    );

endmodule

`default_nettype wire

/* verification/tb_core_front.sv */
`default_nettype none

module tb_core_front import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst_n;
    logic [XLEN-1:0]       instr;
    logic                  instr_valid;
    logic                  stall;
    logic                  flush;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  wb_reg_write;
    logic [6:0]            id_opcode;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [2:0]            id_funct3;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [6:0]            id_funct7;
    logic                  id_reg_write;
    logic                  id_mem_read;
    logic                  id_mem_write;
    wb_sel_e               id_wb_sel;
    logic [3:0]            id_d_size;
    logic                  id_d_unsigned;
    logic                  id_dma_en;
    logic [XLEN-1:0]       id_imm;
    logic [XLEN-1:0]       id_rs1_data;
    logic [XLEN-1:0]       id_rs2_data;
    logic [XLEN-1:0]       id_pc;
    logic                  id_valid;
    logic                  id_illegal;

    logic [31:0] lfsr_q;
    logic [31:0] exp_pc;  // Pc of the next accepted word

    core_front_top UUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .instr_i         (instr),
        .instr_valid_i   (instr_valid),
        .stall_i         (stall),
        .flush_i         (flush),
        .wb_rd_i         (wb_rd),
        .wb_data_i       (wb_data),
        .wb_reg_write_i  (wb_reg_write),
        .id_opcode_o     (id_opcode),
        .id_rd_o         (id_rd),
        .id_funct3_o     (id_funct3),
        .id_rs1_o        (id_rs1),
        .id_rs2_o        (id_rs2),
        .id_funct7_o     (id_funct7),
        .id_reg_write_o  (id_reg_write),
        .id_mem_read_o   (id_mem_read),
        .id_mem_write_o  (id_mem_write),
        .id_wb_sel_o     (id_wb_sel),
        .id_d_size_o     (id_d_size),
        .id_d_unsigned_o (id_d_unsigned),
        .id_dma_en_o     (id_dma_en),
        .id_imm_o        (id_imm),
        .id_rs1_data_o   (id_rs1_data),
        .id_rs2_data_o   (id_rs2_data),
        .id_pc_o         (id_pc),
        .id_valid_o      (id_valid),
        .id_illegal_o    (id_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = galois_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic logic [3:0] model_size(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return DSIZE_B;
            2'd1:    return DSIZE_H;
            2'd2:    return DSIZE_W;
            default: return DSIZE_NONE;
        endcase
    endfunction

    task automatic model_controls(input logic [31:0] word, output logic rw,
                                  output logic mr, output logic mw, output wb_sel_e wb,
                                  output logic [3:0] size, output logic uns,
                                  output logic dma);
        logic [6:0] f7;
        f7 = word[31:25];
        rw = 1'b0;
        mr = 1'b0;
        mw = 1'b0;
        wb = WB_NONE;
        size = DSIZE_NONE;
        uns = 1'b0;
        dma = 1'b0;
        if (word[1:0] == 2'b11) begin  // Illegal words keep everything idle
            case (opcode_e'(word[6:0]))
                OPC_LOAD: begin
                    rw = 1'b1;
                    mr = 1'b1;
                    wb = WB_MEM;
                    size = model_size(word[14:12]);
                    uns = word[14];
                end
                OPC_STORE: begin
                    mw = 1'b1;
                    size = model_size(word[14:12]);
                end
                OPC_LUI: begin
                    rw = 1'b1;
                    wb = WB_IMM;
                end
                OPC_AUIPC, OPC_OP_IMM: begin
                    rw = 1'b1;
                    wb = WB_ALU;
                end
                OPC_JAL, OPC_JALR: begin
                    rw = 1'b1;
                    wb = WB_PC4;
                end
                OPC_OP: begin
                    if (f7 == 7'h00 || f7 == 7'h20) begin
                        rw = 1'b1;
                        wb = WB_ALU;
                    end
                end
                OPC_CUSTOM0: dma = 1'b1;
                default: ;
            endcase
        end
    endtask

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        logic signed [31:0] v;
        case (opcode_e'(w[6:0]))
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM: v = $signed(w[31:20]);
            OPC_STORE:  v = $signed({w[31:25], w[11:7]});
            OPC_BRANCH: v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            OPC_LUI, OPC_AUIPC: v = {w[31:12], 12'h000};
            OPC_JAL:    v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default:    v = '0;
        endcase
        return v;
    endfunction

    // Strobe one word and wait for it in decode
    task automatic issue(input logic [31:0] word);
        int cycles;
        instr = word;
        instr_valid = 1'b1;
        next_cycle();
        instr_valid = 1'b0;
        cycles = 0;
        while (id_valid !== 1'b1) begin
            if (cycles >= 8) begin
                $display("Timeout: id_valid_o never rose after an instruction strobe");
                $display("RESULT: FAIL");
                $fatal(1, "Decode timeout");
            end else begin
                next_cycle();
                cycles++;
            end
        end
        check_equal(id_pc, exp_pc, "pc");
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic check_decode(input logic [31:0] word);
        logic       rw;
        logic       mr;
        logic       mw;
        logic       uns;
        logic       dma;
        wb_sel_e    wb;
        logic [3:0] size;
        model_controls(word, rw, mr, mw, wb, size, uns, dma);
        check_equal(id_valid, 1'b1, "valid");
        check_equal(id_illegal, word[1:0] != 2'b11, "illegal");
        check_equal(id_opcode, word[6:0], "opcode");
        check_equal(id_rd, word[11:7], "rd");
        check_equal(id_funct3, word[14:12], "funct3");
        check_equal(id_rs1, word[19:15], "rs1");
        check_equal(id_rs2, word[24:20], "rs2");
        check_equal(id_funct7, word[31:25], "funct7");
        check_equal(id_reg_write, rw, "reg_write");
        check_equal(id_mem_read, mr, "mem_read");
        check_equal(id_mem_write, mw, "mem_write");
        check_equal(32'(id_wb_sel), 32'(wb), "wb_sel");
        check_equal(id_d_size, size, "d_size");
        check_equal(id_d_unsigned, uns, "d_unsigned");
        check_equal(id_dma_en, dma, "dma_en");
        check_equal(id_imm, model_imm(word), "immediate");
    endtask

    task automatic check_idle(input string when);
        check_equal(id_valid, 1'b0, {"valid ", when});
        check_equal(id_illegal, 1'b0, {"illegal ", when});
        check_equal(id_reg_write, 1'b0, {"reg_write ", when});
        check_equal(id_mem_read, 1'b0, {"mem_read ", when});
        check_equal(id_mem_write, 1'b0, {"mem_write ", when});
        check_equal(32'(id_wb_sel), 32'(WB_NONE), {"wb_sel ", when});
        check_equal(id_d_size, DSIZE_NONE, {"d_size ", when});
        check_equal(id_d_unsigned, 1'b0, {"d_unsigned ", when});
        check_equal(id_dma_en, 1'b0, {"dma_en ", when});
    endtask

    task automatic test_reset_idle();
        check_idle("after reset");
        issue(32'h0050_0093);  // addi x1, x0, 5 at RESET_PC
        check_decode(32'h0050_0093);
        issue(32'h1234_5137);  // lui x2, 0x12345
        check_decode(32'h1234_5137);
    endtask

    task automatic test_decode_sweep();
        opcode_e     ops [11];
        logic [31:0] r;
        logic [31:0] word;
        ops = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_SYSTEM, OPC_CUSTOM0};
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 11; i++) begin
                rand_bits(25, r);
                word = {r[24:0], ops[i]};
                issue(word);
                check_decode(word);
            end
        end
    endtask

    task automatic test_register_file();
        logic [4:0]  addr [4];
        logic [31:0] shadow [32];
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] word;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            rand_bits(5, r);
            rand_bits(32, data);
            addr[i] = (i == 0) ? 5'd0 : r[4:0];  // First write targets x0
            wb_rd = addr[i];
            wb_data = data;
            wb_reg_write = 1'b1;
            next_cycle();
            wb_reg_write = 1'b0;
            if (addr[i] != 5'd0) begin
                shadow[addr[i]] = data;
            end
        end
        for (int k = 0; k < 4; k++) begin
            rand_bits(5, r);
            word = {7'b000_0000, addr[(k + 1) % 4], addr[k], 3'b000, r[4:0], OPC_OP};
            issue(word);
            check_decode(word);
            check_equal(id_rs1_data, shadow[addr[k]], "rs1_data");
            check_equal(id_rs2_data, shadow[addr[(k + 1) % 4]], "rs2_data");
        end
    endtask

    task automatic test_stall_flush();
        issue(32'h0083_2183);  // lw x3, 8(x6)
        check_decode(32'h0083_2183);
        stall = 1'b1;
        instr = 32'h0010_0213;  // Dropped while stalled
        instr_valid = 1'b1;
        next_cycle();
        instr_valid = 1'b0;
        next_cycle();
        check_decode(32'h0083_2183);
        check_equal(id_pc, exp_pc - 32'd4, "pc held in stall");
        stall = 1'b0;
        next_cycle();
        check_idle("after stall");
        issue(32'h0041_2623);  // sw x4, 12(x2) takes the next pc
        check_decode(32'h0041_2623);
        stall = 1'b1;
        flush = 1'b1;
        next_cycle();
        check_idle("after flush");
        flush = 1'b0;
        stall = 1'b0;
    endtask

    task automatic test_illegal();
        logic [31:0] r;
        logic [31:0] word;
        rand_bits(32, r);
        word = {r[31:2], 2'b01};
        issue(word);
        check_decode(word);
        issue(32'h0050_0093);
        check_decode(32'h0050_0093);
    endtask

    initial begin
        lfsr_q = 32'd97424;
        exp_pc = RESET_PC;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        wb_reg_write = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_idle();
        test_decode_sweep();
        test_register_file();
        test_stall_flush();
        test_illegal();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/core_pkg.sv
design/core_if_stage.sv
design/core_if_id_reg.sv
design/core_decoder.sv
design/core_imm_gen.sv
design/core_regfile.sv
design/core_id_stage.sv
design/core_front_top.sv
verification/tb_core_front.sv

/* Bender.yml */
package:
  name: core_front

sources:
  - design/core_pkg.sv
  - design/core_if_stage.sv
  - design/core_if_id_reg.sv
  - design/core_decoder.sv
  - design/core_imm_gen.sv
  - design/core_regfile.sv
  - design/core_id_stage.sv
  - design/core_front_top.sv
  - target: test
    files:
      - verification/tb_core_front.sv
